// File: Bender.yml
package:
  name: mips_core

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - fetch_unit.sv
  - regfile.sv
  - decode_stage.sv
  - execute_stage.sv
  - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core.sv

// File: core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter isa_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    output pipe_pkg::ibus_req_t  ibus_req,
    input  pipe_pkg::ibus_resp_t ibus_resp,
    output pipe_pkg::retire_t    retire
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_t    fetch;
    issue_t    issue;
    redirect_t redirect;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk,
        .reset,
        .redirect,
        .ibus_resp,
        .ibus_req,
        .fetch
    );

    decode_stage u_decode (
        .clk,
        .reset,
        .fetch,
        .redirect,
        .ra1,
        .ra2,
        .rd1,
        .rd2,
        .issue
    );

    // written from the retire record
    regfile u_regfile (
        .clk,
        .reset,
        .ra1,
        .ra2,
        .rd1,
        .rd2,
        .wb(retire)
    );

    execute_stage u_execute (
        .clk,
        .reset,
        .issue,
        .redirect,
        .retire
    );

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::fetch_t    fetch,
    input  pipe_pkg::redirect_t redirect,
    output isa_pkg::reg_addr_t  ra1,
    output isa_pkg::reg_addr_t  ra2,
    input  isa_pkg::word_t      rd1,
    input  isa_pkg::word_t      rd2,
    output pipe_pkg::issue_t    issue
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t    instr;
    ctl_t      ctl;
    word_t     imm;
    word_t     pc_plus4;
    reg_addr_t wa;

    assign instr    = fetch.instr;
    assign pc_plus4 = fetch.pc + 32'd4;
    assign ra1      = instr.r.rs;
    assign ra2      = instr.r.rt;

    always_comb begin
        // unknown encodings fall through as a no-op
        ctl.alu_op   = alu_add;
        ctl.use_imm  = 1'b0;
        ctl.regwrite = 1'b0;
        ctl.branch   = br_none;
        imm          = {{16{instr.i.imm[15]}}, instr.i.imm};
        wa           = instr.r.rd;
        case (instr.r.opcode)
            op_special: begin
                ctl.regwrite = 1'b1;
                case (instr.r.funct)
                    fn_addu: ctl.alu_op = alu_add;
                    fn_subu: ctl.alu_op = alu_sub;
                    fn_and:  ctl.alu_op = alu_and;
                    fn_or:   ctl.alu_op = alu_or;
                    fn_xor:  ctl.alu_op = alu_xor;
                    fn_slt:  ctl.alu_op = alu_slt;
                    default: ctl.regwrite = 1'b0;
                endcase
            end
            op_addiu, op_ori, op_lui: begin
                ctl.use_imm  = 1'b1;
                ctl.regwrite = 1'b1;
                wa           = instr.i.rt;
                if (instr.i.opcode == op_ori) begin
                    ctl.alu_op = alu_or;
                    imm        = {16'h0000, instr.i.imm};
                end else if (instr.i.opcode == op_lui) begin
                    ctl.alu_op = alu_lui;
                    imm        = {instr.i.imm, 16'h0000};
                end
            end
            op_beq: ctl.branch = br_beq;
            op_bne: ctl.branch = br_bne;
            op_j: begin
                ctl.branch = br_jump;
                imm        = {pc_plus4[31:28], instr.j.index, 2'b00};
            end
            default: ;
        endcase
        // writes to r0 are dropped here, not in the register file
        if (wa == '0) begin
            ctl.regwrite = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= fetch.valid && !redirect.valid;
        end
        issue.pc  <= fetch.pc;
        issue.ctl <= ctl;
        issue.ra1 <= ra1;
        issue.ra2 <= ra2;
        issue.wa  <= wa;
        issue.rd1 <= rd1;
        issue.rd2 <= rd2;
        issue.imm <= imm;
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::issue_t    issue,
    output pipe_pkg::redirect_t redirect,
    output pipe_pkg::retire_t   retire
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t op_b;
    word_t alu_out;
    word_t br_target;
    logic  fwd_ok;
    logic  taken;

    // bypass from the instruction retiring this cycle
    assign fwd_ok = retire.valid && retire.regwrite;
    assign src_a  = (fwd_ok && retire.wa == issue.ra1) ? retire.wd : issue.rd1;
    assign src_b  = (fwd_ok && retire.wa == issue.ra2) ? retire.wd : issue.rd2;
    assign op_b   = issue.ctl.use_imm ? issue.imm : src_b;

    always_comb begin
        case (issue.ctl.alu_op)
            alu_add: alu_out = src_a + op_b;
            alu_sub: alu_out = src_a - op_b;
            alu_and: alu_out = src_a & op_b;
            alu_or:  alu_out = src_a | op_b;
            alu_xor: alu_out = src_a ^ op_b;
            alu_slt: alu_out = {31'b0, $signed(src_a) < $signed(op_b)};
            alu_lui: alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (issue.ctl.branch)
            br_beq:  taken = (src_a == src_b);
            br_bne:  taken = (src_a != src_b);
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // no delay slot, offset counts from pc+4
    assign br_target = (issue.ctl.branch == br_jump) ? issue.imm
                     : issue.pc + 32'd4 + {issue.imm[29:0], 2'b00};

    assign redirect.valid  = issue.valid && taken;
    assign redirect.target = br_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= issue.valid;
        end
        retire.pc       <= issue.pc;
        retire.regwrite <= issue.ctl.regwrite;
        retire.wa       <= issue.wa;
        retire.wd       <= alu_out;
    end

    // a taken branch kills whatever decode held behind it
    assert property (@(posedge clk) disable iff (reset)
        redirect.valid |-> issue.valid ##1 !issue.valid)
        else $error("younger instruction survived a redirect");

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter isa_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::redirect_t  redirect,
    input  pipe_pkg::ibus_resp_t ibus_resp,
    output pipe_pkg::ibus_req_t  ibus_req,
    output pipe_pkg::fetch_t     fetch
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t pc;
    word_t req_pc;
    logic  started;
    logic  pending;
    logic  stale;
    logic  accept;

    // next request may go out in the cycle the previous data returns
    assign ibus_req.valid = started && (!pending || ibus_resp.data_ok);
    assign ibus_req.addr  = pc;
    assign accept         = ibus_req.valid && ibus_resp.addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            pending <= 1'b0;
            stale   <= 1'b0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                pending <= 1'b1;
                // accepted under a redirect means wrong path
                stale   <= redirect.valid;
            end else if (ibus_resp.data_ok) begin
                pending <= 1'b0;
                stale   <= 1'b0;
            end else if (redirect.valid && pending) begin
                stale <= 1'b1;
            end
        end
    end

    // redirect wins over sequential advance
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_pc <= pc;
        end
    end

    // returned word goes to decode for one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= ibus_resp.data_ok && !stale && !redirect.valid;
        end
        fetch.pc        <= req_pc;
        fetch.instr.raw <= ibus_resp.data;
    end

    // the memory only answers a request it has accepted
    assert property (@(posedge clk) disable iff (reset)
        ibus_resp.data_ok |-> pending)
        else $error("data_ok without an outstanding request");

endmodule

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f
    } opcode_e;

    // function field, only meaningful under op_special
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_format_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_format_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] index;
    } j_format_t;

    // same 32 bits, seen as whichever format the opcode calls for
    typedef union packed {
        r_format_t r;
        i_format_t i;
        j_format_t j;
        word_t     raw;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none, br_beq, br_bne, br_jump
    } branch_e;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // instruction bus, one outstanding request
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic           addr_ok;
        logic           data_ok;
        isa_pkg::word_t data;
    } ibus_resp_t;

    typedef struct packed {
        logic            valid;
        isa_pkg::word_t  pc;
        isa_pkg::instr_t instr;
    } fetch_t;

    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             use_imm;
        logic             regwrite;
        isa_pkg::branch_e branch;
    } ctl_t;

    // decode to execute, imm holds the jump target for j
    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        ctl_t               ctl;
        isa_pkg::reg_addr_t ra1;
        isa_pkg::reg_addr_t ra2;
        isa_pkg::reg_addr_t wa;
        isa_pkg::word_t     rd1;
        isa_pkg::word_t     rd2;
        isa_pkg::word_t     imm;
    } issue_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t target;
    } redirect_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        logic               regwrite;
        isa_pkg::reg_addr_t wa;
        isa_pkg::word_t     wd;
    } retire_t;

endpackage

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::reg_addr_t  ra1,
    input  isa_pkg::reg_addr_t  ra2,
    output isa_pkg::word_t      rd1,
    output isa_pkg::word_t      rd2,
    input  pipe_pkg::retire_t   wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [31:1];
    logic  wen;

    assign wen = wb.valid && wb.regwrite && (wb.wa != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wb.wa] <= wb.wd;
        end
    end

    // r0 is hardwired, a write in flight is seen right away
    assign rd1 = (ra1 == '0) ? '0 : (wen && wb.wa == ra1) ? wb.wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (wen && wb.wa == ra2) ? wb.wd : regs[ra2];

    // decode already drops r0 writes
    assert property (@(posedge clk) disable iff (reset)
        (wb.valid && wb.regwrite) |-> (wb.wa != '0))
        else $error("register write aimed at r0");

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
fetch_unit.sv
regfile.sv
decode_stage.sv
execute_stage.sv
core_top.sv
tb_core.sv

// File: tb_tasks.svh
`ifndef tb_tasks_svh
`define tb_tasks_svh
`default_nettype none

// assembler helpers, operands in assembly order
function automatic word_t r_word(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {op_special, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t i_word(opcode_e op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t j_word(word_t target);
    return {op_j, target[27:2]};
endfunction

function automatic word_t idx_addr(int idx);
    return reset_pc + 32'(idx * 4);
endfunction

// offset counted from the slot after the branch
function automatic logic [15:0] br_off(int from_idx, int to_idx);
    return 16'(to_idx - from_idx - 1);
endfunction

task automatic clear_program();
    for (int i = 0; i < imem_depth; i++) begin
        imem[i] = fill_word(idx_addr(i));
    end
    prog_len = 0;
endtask

task automatic put_word(word_t w);
    imem[prog_len] = w;
    prog_len = prog_len + 1;
endtask

// jump to itself marks the end of a program
task automatic put_halt();
    halt_pc = idx_addr(prog_len);
    put_word(j_word(halt_pc));
endtask

task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp) begin
        $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_retire(retire_t got, retire_t exp, string what);
    logic bad;
    bad = (got.valid !== exp.valid) || (got.pc !== exp.pc)
        || (got.regwrite !== exp.regwrite);
    if (exp.regwrite) begin
        bad = bad || (got.wa !== exp.wa) || (got.wd !== exp.wd);
    end
    if (bad) begin
        $display("[ERROR] %0t: %s: got pc %h rw %b r%0d=%h, expected pc %h rw %b r%0d=%h",
                 $time, what, got.pc, got.regwrite, got.wa, got.wd,
                 exp.pc, exp.regwrite, exp.wa, exp.wd);
        abort_run();
    end
endtask

task automatic apply_reset(input logic random_bus);
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < 10; i++) begin
        @(negedge clk);
        bus_random = random_bus;
        check_word({31'b0, retire.valid}, '0, "retire.valid during reset");
        check_word({31'b0, ibus_req.valid}, '0, "ibus_req.valid during reset");
    end
    reset = 1'b0;
    @(negedge clk);
    check_word({31'b0, retire.valid}, '0, "retire.valid after reset");
    check_word({31'b0, ibus_req.valid}, 32'd1, "first request valid");
    check_word(ibus_req.addr, reset_pc, "first request address");
endtask

// runs the loaded program until the halt retires
task automatic run_program(input logic random_bus);
    retire_t exp;
    logic    done;
    apply_reset(random_bus);
    foreach (m_regs[i]) begin
        m_regs[i] = '0;
    end
    m_pc = reset_pc;
    retired.delete();
    done = 1'b0;
    while (!done) begin
        @(negedge clk);
        if (retire.valid) begin
            model_step(exp);
            check_retire(retire, exp, "retire record");
            retired.push_back(retire);
            done = (retire.pc == halt_pc);
        end
    end
endtask

task automatic put_branch_program();
    put_word(i_word(op_addiu, 5'd1, 5'd0, 16'd5));
    put_word(i_word(op_addiu, 5'd2, 5'd0, 16'd5));
    // taken, skips two wrong-path words
    put_word(i_word(op_beq, 5'd2, 5'd1, br_off(2, 5)));
    put_word(i_word(op_addiu, 5'd3, 5'd0, 16'd1));
    put_word(i_word(op_addiu, 5'd3, 5'd0, 16'd2));
    // two not taken, then a taken bne
    put_word(i_word(op_bne, 5'd2, 5'd1, br_off(5, 9)));
    put_word(i_word(op_beq, 5'd0, 5'd1, br_off(6, 9)));
    put_word(i_word(op_bne, 5'd0, 5'd1, br_off(7, 9)));
    put_word(i_word(op_addiu, 5'd4, 5'd0, 16'd7));
    put_word(j_word(idx_addr(11)));
    put_word(i_word(op_addiu, 5'd5, 5'd0, 16'd9));
    put_word(i_word(op_addiu, 5'd6, 5'd0, 16'd1));
    put_halt();
endtask

task automatic reset_behavior();
    clear_program();
    put_word(i_word(op_addiu, 5'd1, 5'd0, 16'd1));
    put_halt();
    run_program(1'b1);
    check_word(first_addr, reset_pc, "first accepted address");
endtask

task automatic alu_coverage();
    word_t       a;
    word_t       b;
    logic [15:0] k;
    clear_program();
    for (int n = 0; n < 4; n++) begin
        a = $urandom();
        b = $urandom();
        k = 16'($urandom());
        put_word(i_word(op_lui, 5'd1, 5'd0, a[31:16]));
        put_word(i_word(op_ori, 5'd1, 5'd1, a[15:0]));
        put_word(i_word(op_lui, 5'd2, 5'd0, b[31:16]));
        put_word(i_word(op_ori, 5'd2, 5'd2, b[15:0]));
        put_word(r_word(fn_addu, 5'd3, 5'd1, 5'd2));
        put_word(r_word(fn_subu, 5'd4, 5'd1, 5'd2));
        put_word(r_word(fn_and, 5'd5, 5'd1, 5'd2));
        put_word(r_word(fn_or, 5'd6, 5'd1, 5'd2));
        put_word(r_word(fn_xor, 5'd7, 5'd1, 5'd2));
        put_word(r_word(fn_slt, 5'd8, 5'd1, 5'd2));
        put_word(i_word(op_addiu, 5'd9, 5'd1, k));
        put_word(i_word(op_ori, 5'd10, 5'd2, k));
        put_word(i_word(op_lui, 5'd11, 5'd0, k));
    end
    put_halt();
    run_program(1'b0);
endtask

// producers reused at distance 1, 2 and 3
task automatic forwarding_chains();
    clear_program();
    put_word(i_word(op_addiu, 5'd1, 5'd0, 16'd3));
    put_word(r_word(fn_addu, 5'd2, 5'd1, 5'd1));
    put_word(r_word(fn_subu, 5'd3, 5'd2, 5'd1));
    put_word(r_word(fn_xor, 5'd4, 5'd3, 5'd1));
    put_word(r_word(fn_or, 5'd5, 5'd2, 5'd4));
    put_word(r_word(fn_slt, 5'd6, 5'd3, 5'd5));
    put_word(i_word(op_addiu, 5'd7, 5'd6, 16'hffff));
    put_word(r_word(fn_and, 5'd8, 5'd7, 5'd5));
    put_halt();
    run_program(1'b0);
endtask

task automatic branch_redirect();
    clear_program();
    put_branch_program();
    run_program(1'b0);
endtask

task automatic stalled_redirect();
    clear_program();
    put_word(i_word(op_addiu, 5'd1, 5'd0, 16'd6));
    put_word(i_word(op_addiu, 5'd2, 5'd0, 16'd0));
    // six passes through a three-word loop
    put_word(i_word(op_addiu, 5'd2, 5'd2, 16'd3));
    put_word(i_word(op_addiu, 5'd1, 5'd1, 16'hffff));
    put_word(i_word(op_bne, 5'd0, 5'd1, br_off(4, 2)));
    put_word(j_word(idx_addr(7)));
    put_word(i_word(op_addiu, 5'd9, 5'd0, 16'd1));
    put_word(r_word(fn_or, 5'd3, 5'd2, 5'd1));
    put_halt();
    run_program(1'b1);
    clear_program();
    put_branch_program();
    run_program(1'b1);
endtask

task automatic zero_register();
    clear_program();
    put_word(i_word(op_addiu, 5'd1, 5'd0, 16'd7));
    put_word(i_word(op_addiu, 5'd0, 5'd0, 16'd5));
    put_word(r_word(fn_addu, 5'd0, 5'd1, 5'd1));
    // unknown opcode, retires as a no-op
    put_word(32'hfc00_1234);
    put_word(r_word(fn_or, 5'd4, 5'd0, 5'd0));
    put_word(r_word(fn_addu, 5'd5, 5'd0, 5'd1));
    put_halt();
    run_program(1'b0);
    check_word({31'b0, retired[1].regwrite}, '0, "addiu to r0 regwrite");
    check_word({31'b0, retired[2].regwrite}, '0, "addu to r0 regwrite");
    check_word(retired[4].wd, '0, "read of r0");
endtask

`default_nettype wire
`endif

// File: tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam word_t reset_pc   = 32'hbfc0_0000;
    localparam int    imem_depth = 256;
    // retires over all six tests, 40 cycles allowed for each
    localparam int    total_instrs    = 112;
    localparam int    watchdog_cycles = total_instrs * 40;

    logic       clk = 1'b0;
    logic       reset;
    ibus_req_t  ibus_req;
    ibus_resp_t ibus_resp;
    retire_t    retire;

    // program image and reference model state
    word_t   imem [imem_depth];
    int      prog_len;
    word_t   halt_pc;
    word_t   m_regs [32];
    word_t   m_pc;
    retire_t retired [$];

    // bus model state, sampled on the rising edge
    logic  bus_random = 1'b0;
    logic  took_req   = 1'b0;
    logic  in_reset   = 1'b1;
    word_t took_addr;
    word_t first_addr;

    always #2 clk = ~clk;

    core_top #(
        .reset_pc(reset_pc)
    ) u_dut (
        .clk,
        .reset,
        .ibus_req,
        .ibus_resp,
        .retire
    );

    // unused words decode as an unknown opcode
    function automatic word_t fill_word(word_t addr);
        return 32'hfc00_0000 | ((addr ^ (addr >> 16)) & 32'h03ff_ffff);
    endfunction

    function automatic word_t mem_read(word_t addr);
        word_t off;
        off = addr - reset_pc;
        if (off < imem_depth * 4) begin
            return imem[off[31:2]];
        end
        return fill_word(addr);
    endfunction

    always @(posedge clk) begin
        took_req  = ibus_req.valid && ibus_resp.addr_ok;
        took_addr = ibus_req.addr;
        in_reset  = reset;
    end

    // instruction memory, data returns 1 to 3 cycles after accept
    initial begin
        logic  busy;
        logic  seen_first;
        word_t busy_addr;
        int    wait_left;
        ibus_resp  = '0;
        busy       = 1'b0;
        seen_first = 1'b0;
        forever begin
            @(negedge clk);
            ibus_resp.data_ok = 1'b0;
            if (in_reset) begin
                busy              = 1'b0;
                seen_first        = 1'b0;
                ibus_resp.addr_ok = 1'b0;
            end else begin
                if (took_req) begin
                    if (!seen_first) begin
                        first_addr = took_addr;
                        seen_first = 1'b1;
                    end
                    busy      = 1'b1;
                    busy_addr = took_addr;
                    wait_left = bus_random ? 1 + $urandom_range(2) : 1;
                end
                if (busy) begin
                    wait_left = wait_left - 1;
                    if (wait_left == 0) begin
                        ibus_resp.data_ok = 1'b1;
                        ibus_resp.data    = mem_read(busy_addr);
                        busy              = 1'b0;
                    end
                end
                ibus_resp.addr_ok = bus_random ? ($urandom_range(3) != 0) : 1'b1;
            end
        end
    end

    // one architectural step, the expected retire record
    task automatic model_step(output retire_t exp);
        instr_t    ins;
        word_t     a;
        word_t     b;
        word_t     imm_s;
        word_t     res;
        word_t     next_pc;
        logic      wr;
        reg_addr_t dst;
        ins.raw = mem_read(m_pc);
        a       = m_regs[ins.r.rs];
        b       = m_regs[ins.r.rt];
        imm_s   = {{16{ins.i.imm[15]}}, ins.i.imm};
        res     = '0;
        wr      = 1'b0;
        dst     = ins.r.rd;
        next_pc = m_pc + 32'd4;
        case (ins.r.opcode)
            op_special: begin
                wr = 1'b1;
                case (ins.r.funct)
                    fn_addu: res = a + b;
                    fn_subu: res = a - b;
                    fn_and:  res = a & b;
                    fn_or:   res = a | b;
                    fn_xor:  res = a ^ b;
                    fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            op_addiu: begin
                wr  = 1'b1;
                dst = ins.i.rt;
                res = a + imm_s;
            end
            op_ori: begin
                wr  = 1'b1;
                dst = ins.i.rt;
                res = a | {16'h0000, ins.i.imm};
            end
            op_lui: begin
                wr  = 1'b1;
                dst = ins.i.rt;
                res = {ins.i.imm, 16'h0000};
            end
            op_beq: begin
                if (a == b) begin
                    next_pc = m_pc + 32'd4 + (imm_s << 2);
                end
            end
            op_bne: begin
                if (a != b) begin
                    next_pc = m_pc + 32'd4 + (imm_s << 2);
                end
            end
            op_j: next_pc = {next_pc[31:28], ins.j.index, 2'b00};
            default: ;
        endcase
        if (dst == 5'd0) begin
            wr = 1'b0;
        end
        exp          = '0;
        exp.valid    = 1'b1;
        exp.pc       = m_pc;
        exp.regwrite = wr;
        exp.wa       = dst;
        exp.wd       = res;
        if (wr) begin
            m_regs[dst] = res;
        end
        m_pc = next_pc;
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        void'($urandom(32'h7022_3925));
        reset = 1'b1;
        reset_behavior();
        alu_coverage();
        forwarding_chains();
        branch_redirect();
        stalled_redirect();
        zero_register();
        $display("Simulation PASSED");
        $finish;
    end

    `include "tb_tasks.svh"

endmodule

`default_nettype wire
